// File: src/mips_isa_pkg.sv
`default_nettype none

//////////////////////////////
// mips32 instruction encoding
//////////////////////////////

package mips_isa_pkg;

    // field widths with a meaning of their own
    typedef logic [31:0] inst_t;     // one instruction word
    typedef logic [5:0]  opcode_t;   // major opcode, bits 31..26
    typedef logic [5:0]  funct_t;    // SPECIAL function code, bits 5..0
    typedef logic [4:0]  reg_addr_t; // gpr number
    typedef logic [4:0]  shamt_t;    // shift amount, bits 10..6
    typedef logic [15:0] imm16_t;    // I-type immediate, bits 15..0

    // R-type view of a word
    //   |31..26|25..21|20..16|15..11|10..6|5..0 |
    //   |  op  |  rs  |  rt  |  rd  | sa  |funct|
    // I-type reuses rd, sa and funct as one 16-bit immediate
    typedef struct packed {
        opcode_t   op;    // major opcode
        reg_addr_t rs;    // source 1, base for pref
        reg_addr_t rt;    // source 2 or I-type target
        reg_addr_t rd;    // R-type target
        shamt_t    sa;    // shift amount
        funct_t    funct; // only valid under SPECIAL
    } inst_fields_t;

    //////////////////////////////
    // major opcodes
    //////////////////////////////

    localparam opcode_t OPC_SPECIAL = 6'b000000; // R-type, decode on funct
    localparam opcode_t OPC_ANDI    = 6'b001100;
    localparam opcode_t OPC_ORI     = 6'b001101;
    localparam opcode_t OPC_XORI    = 6'b001110;
    localparam opcode_t OPC_LUI     = 6'b001111; // rs field unused
    localparam opcode_t OPC_PREF    = 6'b110011; // hint only, no effect here

    //////////////////////////////
    // SPECIAL function codes
    //////////////////////////////

    // logic on two registers
    localparam funct_t FN_AND  = 6'b100100;
    localparam funct_t FN_OR   = 6'b100101;
    localparam funct_t FN_XOR  = 6'b100110;
    localparam funct_t FN_NOR  = 6'b100111;

    // shift by sa
    localparam funct_t FN_SLL  = 6'b000000; // nop and ssnop share this
    localparam funct_t FN_SRL  = 6'b000010;
    localparam funct_t FN_SRA  = 6'b000011;

    // shift by rs[4:0]
    localparam funct_t FN_SLLV = 6'b000100;
    localparam funct_t FN_SRLV = 6'b000110;
    localparam funct_t FN_SRAV = 6'b000111;

    localparam funct_t FN_SYNC = 6'b001111; // memory barrier, nop here

    // whole-word encodings that alias sll r0, r0, sa
    // they must never write, so decode matches them before funct
    localparam inst_t INST_NOP   = 32'h0000_0000; // sa = 0
    localparam inst_t INST_SSNOP = 32'h0000_0040; // sa = 1

endpackage

`default_nettype wire

// File: src/id_pkg.sv
`default_nettype none

//////////////////////////////
// decode stage types
//////////////////////////////

package id_pkg;

    typedef logic [31:0] word_t;   // datapath word
    typedef logic [2:0]  alusel_t; // which ALU result mux leg
    typedef logic [7:0]  aluop_t;  // operation within the class

    // alu class
    localparam alusel_t SEL_NOP   = 3'b000;
    localparam alusel_t SEL_LOGIC = 3'b001;
    localparam alusel_t SEL_SHIFT = 3'b010;

    // alu operations, nop must stay all zero so a cleared
    // ID/EX register reads as a bubble
    localparam aluop_t OP_NOP  = 8'b0000_0000;
    localparam aluop_t OP_AND  = 8'b0010_0100;
    localparam aluop_t OP_OR   = 8'b0010_0101;
    localparam aluop_t OP_XOR  = 8'b0010_0110;
    localparam aluop_t OP_NOR  = 8'b0010_0111;
    localparam aluop_t OP_ANDI = 8'b0101_1001;
    localparam aluop_t OP_ORI  = 8'b0101_1010;
    localparam aluop_t OP_XORI = 8'b0101_1011;
    localparam aluop_t OP_LUI  = 8'b0101_1100;
    localparam aluop_t OP_SLL  = 8'b0111_1100;
    localparam aluop_t OP_SRL  = 8'b0000_0010;
    localparam aluop_t OP_SRA  = 8'b0000_0011;
    localparam aluop_t OP_SLLV = 8'b0000_0100;
    localparam aluop_t OP_SRLV = 8'b0000_0110;
    localparam aluop_t OP_SRAV = 8'b0000_0111;

    // regfile read request, addr is zero while en is low
    typedef struct packed {
        logic                   en;
        mips_isa_pkg::reg_addr_t addr;
    } rd_port_t; // 6 bits

    // write-back bus from ex or mem, used for forwarding
    typedef struct packed {
        logic                   wreg; // bus carries a gpr write
        mips_isa_pkg::reg_addr_t addr;
        word_t                  data;
    } wb_fwd_t; // 38 bits

    // control half of the ID/EX bundle
    typedef struct packed {
        alusel_t                alusel;
        aluop_t                 aluop;
        logic                   wreg;      // write-back enable
        mips_isa_pkg::reg_addr_t wreg_addr; // 0 when wreg is low
    } dec_ctrl_t; // 17 bits

    // what execute sees one cycle after decode
    typedef struct packed {
        dec_ctrl_t ctrl;
        word_t     reg1; // operand 1
        word_t     reg2; // operand 2
    } id_ex_t; // 81 bits

endpackage

`default_nettype wire

// File: src/inst_decode.sv
`timescale 1ns/1ps
`default_nettype none

// field split and control decode, purely combinational
module inst_decode (
    input  wire mips_isa_pkg::inst_t i_inst,
    output id_pkg::rd_port_t         o_rd1,  // regfile port 1 request
    output id_pkg::rd_port_t         o_rd2,  // regfile port 2 request
    output id_pkg::word_t            o_imm,  // operand when a port is off
    output id_pkg::dec_ctrl_t        o_ctrl
);

    import mips_isa_pkg::*;
    import id_pkg::*;

    inst_fields_t f;      // R-type view of the word
    imm16_t       imm16;  // I-type view, overlaps rd/sa/funct
    logic         is_nop; // nop or ssnop, both alias sll

    assign f      = inst_fields_t'(i_inst);
    assign imm16  = {f.rd, f.sa, f.funct};
    assign is_nop = (i_inst == INST_NOP) || (i_inst == INST_SSNOP);

    always_comb
    begin
        // bubble by default, anything not matched below stays this way
        o_rd1          = '0;
        o_rd2          = '0;
        o_imm          = '0;
        o_ctrl.alusel    = SEL_NOP;
        o_ctrl.aluop     = OP_NOP;
        o_ctrl.wreg      = 1'b0;
        o_ctrl.wreg_addr = '0;

        if (!is_nop)
        begin
            case (f.op)
                OPC_SPECIAL:
                begin
                    case (f.funct)
                        //////////////////////////////
                        // register logic
                        //////////////////////////////
                        FN_AND, FN_OR, FN_XOR, FN_NOR: // rd <- rs op rt
                        begin
                            o_rd1            = '{en: 1'b1, addr: f.rs};
                            o_rd2            = '{en: 1'b1, addr: f.rt};
                            o_ctrl.alusel    = SEL_LOGIC;
                            o_ctrl.wreg      = 1'b1;
                            o_ctrl.wreg_addr = f.rd;
                            case (f.funct)
                                FN_AND:  o_ctrl.aluop = OP_AND;
                                FN_OR:   o_ctrl.aluop = OP_OR;
                                FN_XOR:  o_ctrl.aluop = OP_XOR;
                                default: o_ctrl.aluop = OP_NOR;
                            endcase
                        end

                        //////////////////////////////
                        // shift by sa
                        //////////////////////////////
                        FN_SLL, FN_SRL, FN_SRA: // rd <- rt shift sa
                        begin
                            o_rd1            = '{en: 1'b1, addr: f.rt};
                            o_imm            = {27'b0, f.sa}; // lands in operand 2
                            o_ctrl.alusel    = SEL_SHIFT;
                            o_ctrl.wreg      = 1'b1;
                            o_ctrl.wreg_addr = f.rd;
                            case (f.funct)
                                FN_SLL:  o_ctrl.aluop = OP_SLL;
                                FN_SRL:  o_ctrl.aluop = OP_SRL;
                                default: o_ctrl.aluop = OP_SRA;
                            endcase
                        end

                        //////////////////////////////
                        // shift by register
                        //////////////////////////////
                        FN_SLLV, FN_SRLV, FN_SRAV: // rd <- rt shift rs[4:0]
                        begin
                            o_rd1            = '{en: 1'b1, addr: f.rt}; // value
                            o_rd2            = '{en: 1'b1, addr: f.rs}; // amount
                            o_ctrl.alusel    = SEL_SHIFT;
                            o_ctrl.wreg      = 1'b1;
                            o_ctrl.wreg_addr = f.rd;
                            case (f.funct)
                                FN_SLLV: o_ctrl.aluop = OP_SLLV;
                                FN_SRLV: o_ctrl.aluop = OP_SRLV;
                                default: o_ctrl.aluop = OP_SRAV;
                            endcase
                        end

                        FN_SYNC:
                        begin
                            // barrier, nothing to order in this core
                            o_ctrl.alusel = SEL_NOP;
                        end

                        default:
                        begin
                            o_ctrl.aluop = OP_NOP; // unknown funct
                        end
                    endcase
                end

                //////////////////////////////
                // immediate logic
                //////////////////////////////
                OPC_ANDI, OPC_ORI, OPC_XORI: // rt <- rs op zext(imm)
                begin
                    o_rd1            = '{en: 1'b1, addr: f.rs};
                    o_imm            = {16'b0, imm16};
                    o_ctrl.alusel    = SEL_LOGIC;
                    o_ctrl.wreg      = 1'b1;
                    o_ctrl.wreg_addr = f.rt; // I-type target
                    case (f.op)
                        OPC_ANDI: o_ctrl.aluop = OP_ANDI;
                        OPC_ORI:  o_ctrl.aluop = OP_ORI;
                        default:  o_ctrl.aluop = OP_XORI;
                    endcase
                end

                OPC_LUI: // rt <- imm << 16, no register read
                begin
                    o_imm            = {imm16, 16'b0};
                    o_ctrl.alusel    = SEL_LOGIC;
                    o_ctrl.aluop     = OP_LUI;
                    o_ctrl.wreg      = 1'b1;
                    o_ctrl.wreg_addr = f.rt;
                end

                //////////////////////////////
                // no-operation group
                //////////////////////////////
                OPC_PREF:
                begin
                    // cache hint, no cache here
                    o_ctrl.alusel = SEL_NOP;
                end

                default:
                begin
                    o_ctrl.aluop = OP_NOP; // undefined opcode
                end
            endcase
        end
    end

endmodule

`default_nettype wire

// File: src/operand_select.sv
`timescale 1ns/1ps
`default_nettype none

// forwarding and immediate mux for both ALU operands
module operand_select (
    input  wire id_pkg::rd_port_t i_rd1,
    input  wire id_pkg::rd_port_t i_rd2,
    input  wire id_pkg::word_t    i_imm,
    input  wire id_pkg::word_t    i_reg1_data, // regfile port 1, same cycle
    input  wire id_pkg::word_t    i_reg2_data, // regfile port 2, same cycle
    input  wire id_pkg::wb_fwd_t  i_ex_fwd,    // result leaving ex
    input  wire id_pkg::wb_fwd_t  i_mem_fwd,   // result leaving mem
    output id_pkg::word_t         o_op1,
    output id_pkg::word_t         o_op2
);

    import id_pkg::*;

    // ex holds the younger write, so it wins over mem
    // r0 gets no special case
    function automatic word_t pick_operand(
        input rd_port_t port,
        input word_t    rf_data,
        input word_t    imm,
        input wb_fwd_t  ex,
        input wb_fwd_t  mem
    );
        if (port.en && ex.wreg && (ex.addr == port.addr))
            return ex.data;  // ex hazard
        else if (port.en && mem.wreg && (mem.addr == port.addr))
            return mem.data; // mem hazard
        else if (port.en)
            return rf_data;  // no hazard
        else
            return imm;      // port off
    endfunction

    assign o_op1 = pick_operand(i_rd1, i_reg1_data, i_imm, i_ex_fwd, i_mem_fwd);
    assign o_op2 = pick_operand(i_rd2, i_reg2_data, i_imm, i_ex_fwd, i_mem_fwd);

endmodule

`default_nettype wire

// File: src/id_ex_reg.sv
`timescale 1ns/1ps
`default_nettype none

// ID/EX pipeline register
module id_ex_reg (
    input  wire                      clk,
    input  wire                      rst,    // sync, active high
    input  wire id_pkg::dec_ctrl_t   i_ctrl,
    input  wire id_pkg::word_t       i_op1,
    input  wire id_pkg::word_t       i_op2,
    output id_pkg::id_ex_t           o_id_ex
);

    import id_pkg::*;

    id_ex_t next_id_ex; // bundle as decode leaves it

    assign next_id_ex = '{ctrl: i_ctrl, reg1: i_op1, reg2: i_op2};

    // no stall input, loads every edge
    always_ff @(posedge clk)
    begin
        if (rst)
            o_id_ex <= '0; // bubble, wreg low and class nop
        else
            o_id_ex <= next_id_ex;
    end

endmodule

`default_nettype wire

// File: src/id_stage.sv
`timescale 1ns/1ps
`default_nettype none

// decode stage top
module id_stage (
    input  wire                       clk,
    input  wire                       rst,
    input  wire mips_isa_pkg::inst_t  i_inst,
    input  wire id_pkg::word_t        i_reg1_data,
    input  wire id_pkg::word_t        i_reg2_data,
    input  wire id_pkg::wb_fwd_t      i_ex_fwd,
    input  wire id_pkg::wb_fwd_t      i_mem_fwd,
    output id_pkg::rd_port_t          o_rd1,   // to regfile, combinational
    output id_pkg::rd_port_t          o_rd2,
    output id_pkg::id_ex_t            o_id_ex  // to execute, registered
);

    import id_pkg::*;

    word_t     imm;  // fallback operand
    dec_ctrl_t ctrl; // control before the register
    word_t     op1;
    word_t     op2;

    //////////////////////////////
    // decode
    //////////////////////////////
    inst_decode u_inst_decode (
        .i_inst (i_inst),
        .o_rd1  (o_rd1),
        .o_rd2  (o_rd2),
        .o_imm  (imm),
        .o_ctrl (ctrl)
    );

    //////////////////////////////
    // operands
    //////////////////////////////
    operand_select u_operand_select (
        .i_rd1       (o_rd1),
        .i_rd2       (o_rd2),
        .i_imm       (imm),
        .i_reg1_data (i_reg1_data),
        .i_reg2_data (i_reg2_data),
        .i_ex_fwd    (i_ex_fwd),
        .i_mem_fwd   (i_mem_fwd),
        .o_op1       (op1),
        .o_op2       (op2)
    );

    // one cycle into execute
    id_ex_reg u_id_ex_reg (
        .clk     (clk),
        .rst     (rst),
        .i_ctrl  (ctrl),
        .i_op1   (op1),
        .i_op2   (op2),
        .o_id_ex (o_id_ex)
    );

endmodule

`default_nettype wire

// File: tb/id_stage_asserts.sv
`timescale 1ns/1ps
`default_nettype none

// properties on the decode stage top, bound into id_stage
module id_stage_asserts (
    input wire                   clk,
    input wire                   rst,
    input wire id_pkg::rd_port_t i_rd1,
    input wire id_pkg::rd_port_t i_rd2,
    input wire id_pkg::id_ex_t   i_id_ex
);

    import id_pkg::*;

    int num_fail = 0; // properties failed so far

    // idle ports show address 0
    a_rd1_idle_addr: assert property (@(posedge clk) !i_rd1.en |-> (i_rd1.addr == '0))
        else
        begin
            num_fail++;
            $error("read port 1 shows an address while disabled");
        end

    a_rd2_idle_addr: assert property (@(posedge clk) !i_rd2.en |-> (i_rd2.addr == '0))
        else
        begin
            num_fail++;
            $error("read port 2 shows an address while disabled");
        end

    // reset leaves a bubble in ID/EX
    a_reset_bubble: assert property (@(posedge clk) rst |=> (i_id_ex == '0))
        else
        begin
            num_fail++;
            $error("ID/EX register not cleared after reset");
        end

    a_nop_no_write: assert property (
        @(posedge clk) (i_id_ex.ctrl.alusel == SEL_NOP) |-> !i_id_ex.ctrl.wreg)
        else
        begin
            num_fail++;
            $error("nop class in ID/EX carries a register write");
        end

endmodule

`default_nettype wire

// File: tb/tb_id_stage.sv
`timescale 1ns/1ps
`default_nettype none

module tb_id_stage;

    import mips_isa_pkg::*;
    import id_pkg::*;

    localparam int CLK_PERIOD = 4;    // ns
    localparam int RST_CYCLES = 8;
    localparam int NUM_INST   = 2000;
    localparam int SLACK      = 20;   // pipeline drain and margin
    localparam int TIMEOUT_NS = (RST_CYCLES + NUM_INST + SLACK) * CLK_PERIOD;

    // what the stage should show for one instruction
    typedef struct packed {
        rd_port_t rd1;
        rd_port_t rd2;
        id_ex_t   id_ex;
    } expect_t;

    logic     clk;
    logic     rst;
    inst_t    inst;
    word_t    reg1_data;
    word_t    reg2_data;
    wb_fwd_t  ex_fwd;
    wb_fwd_t  mem_fwd;
    rd_port_t rd1;
    rd_port_t rd2;
    id_ex_t   id_ex;

    integer   seed = 32'hc033_5a0f;
    expect_t  cur_exp;      // word now on the inputs
    expect_t  prev_exp;     // word now in the ID/EX register
    logic     cur_valid;
    logic     prev_valid;
    int       num_checked;

    id_stage DUT (
        .clk         (clk),
        .rst         (rst),
        .i_inst      (inst),
        .i_reg1_data (reg1_data),
        .i_reg2_data (reg2_data),
        .i_ex_fwd    (ex_fwd),
        .i_mem_fwd   (mem_fwd),
        .o_rd1       (rd1),
        .o_rd2       (rd2),
        .o_id_ex     (id_ex)
    );

    bind id_stage id_stage_asserts u_id_stage_asserts (
        .clk     (clk),
        .rst     (rst),
        .i_rd1   (o_rd1),
        .i_rd2   (o_rd2),
        .i_id_ex (o_id_ex)
    );

    always #(CLK_PERIOD / 2) clk = ~clk;

    task automatic check_value(input string name, input logic [31:0] got,
                               input logic [31:0] exp);
        if (got !== exp)
        begin
            $display("Error %s got %h expected %h", name, got, exp);
            $display("TEST FAILED");
            $fatal(1, "mismatch on %s", name);
        end
    endtask

    //////////////////////////////
    // reference model
    //////////////////////////////

    // enabled port looks at ex, then mem, then the regfile
    function automatic word_t resolve_operand(input rd_port_t port, input word_t rf,
                                              input word_t imm, input wb_fwd_t ex,
                                              input wb_fwd_t mem);
        if (!port.en)
            return imm;
        if (ex.wreg && (ex.addr == port.addr))
            return ex.data;
        if (mem.wreg && (mem.addr == port.addr))
            return mem.data;
        return rf;
    endfunction

    function automatic expect_t reference_decode(input inst_t w, input word_t r1,
                                                 input word_t r2, input wb_fwd_t ex,
                                                 input wb_fwd_t mem);
        expect_t   e;
        int        kind;    // 0 none, 1 reg logic, 2 shift sa, 3 shift reg, 4 imm, 5 lui
        aluop_t    aop;
        alusel_t   sel;
        reg_addr_t dest;
        word_t     imm;
        e    = '0;
        kind = 0;
        aop  = OP_NOP;
        imm  = '0;
        if (w[31:26] == OPC_SPECIAL)
        begin
            case (w[5:0])
                FN_AND:  begin kind = 1; aop = OP_AND;  end
                FN_OR:   begin kind = 1; aop = OP_OR;   end
                FN_XOR:  begin kind = 1; aop = OP_XOR;  end
                FN_NOR:  begin kind = 1; aop = OP_NOR;  end
                FN_SLL:  begin kind = 2; aop = OP_SLL;  end
                FN_SRL:  begin kind = 2; aop = OP_SRL;  end
                FN_SRA:  begin kind = 2; aop = OP_SRA;  end
                FN_SLLV: begin kind = 3; aop = OP_SLLV; end
                FN_SRLV: begin kind = 3; aop = OP_SRLV; end
                FN_SRAV: begin kind = 3; aop = OP_SRAV; end
                default: kind = 0;  // sync and unknown funct
            endcase
        end
        else
        begin
            case (w[31:26])
                OPC_ORI:  begin kind = 4; aop = OP_ORI;  end
                OPC_ANDI: begin kind = 4; aop = OP_ANDI; end
                OPC_XORI: begin kind = 4; aop = OP_XORI; end
                OPC_LUI:  begin kind = 5; aop = OP_LUI;  end
                default:  kind = 0;  // pref and undefined
            endcase
        end
        if ((w == 32'h0000_0000) || (w == 32'h0000_0040))
            kind = 0;  // nop, ssnop
        sel  = (kind == 2 || kind == 3) ? SEL_SHIFT : SEL_LOGIC;
        dest = (kind >= 4) ? w[20:16] : w[15:11];  // rt for I-type
        case (kind)
            1: begin e.rd1 = '{1'b1, w[25:21]}; e.rd2 = '{1'b1, w[20:16]}; end
            2: begin e.rd1 = '{1'b1, w[20:16]}; imm = {27'b0, w[10:6]}; end
            3: begin e.rd1 = '{1'b1, w[20:16]}; e.rd2 = '{1'b1, w[25:21]}; end
            4: begin e.rd1 = '{1'b1, w[25:21]}; imm = {16'b0, w[15:0]}; end
            5: imm = {w[15:0], 16'b0};
            default: imm = '0;
        endcase
        if (kind != 0)
            e.id_ex.ctrl = '{sel, aop, 1'b1, dest};
        e.id_ex.reg1 = resolve_operand(e.rd1, r1, imm, ex, mem);
        e.id_ex.reg2 = resolve_operand(e.rd2, r2, imm, ex, mem);
        return e;
    endfunction

    //////////////////////////////
    // stimulus
    //////////////////////////////

    task automatic random_inst(output inst_t w);
        logic [31:0] r;
        logic [31:0] p;
        int          pick;
        r    = $random(seed);   // field source
        p    = $random(seed);
        pick = int'(p[15:3]) % 18;
        case (pick)
            0:  w = {OPC_SPECIAL, r[25:11], 5'd0, FN_AND};
            1:  w = {OPC_SPECIAL, r[25:11], 5'd0, FN_OR};
            2:  w = {OPC_SPECIAL, r[25:11], 5'd0, FN_XOR};
            3:  w = {OPC_SPECIAL, r[25:11], 5'd0, FN_NOR};
            4:  w = {OPC_SPECIAL, 5'd0, r[20:6], FN_SLL};
            5:  w = {OPC_SPECIAL, 5'd0, r[20:6], FN_SRL};
            6:  w = {OPC_SPECIAL, 5'd0, r[20:6], FN_SRA};
            7:  w = {OPC_SPECIAL, r[25:11], 5'd0, FN_SLLV};
            8:  w = {OPC_SPECIAL, r[25:11], 5'd0, FN_SRLV};
            9:  w = {OPC_SPECIAL, r[25:11], 5'd0, FN_SRAV};
            10: w = {OPC_ORI, r[25:0]};
            11: w = {OPC_ANDI, r[25:0]};
            12: w = {OPC_XORI, r[25:0]};
            13: w = {OPC_LUI, 5'd0, r[20:0]};
            14: w = 32'h0000_0000;                        // nop
            15: w = 32'h0000_0040;                        // ssnop
            16: w = {OPC_SPECIAL, 15'd0, r[10:6], FN_SYNC}; // stype in sa
            default: w = {OPC_PREF, r[25:0]};
        endcase
        if (p[2:0] == 3'd0)
            w = $random(seed);  // undefined word, most of the time
    endtask

    // bus address often forced onto rs or rt
    task automatic random_fwd(input inst_t w, output wb_fwd_t bus);
        logic [31:0] r;
        r        = $random(seed);
        bus.wreg = r[0] | r[1];
        case (r[3:2])
            2'd0:    bus.addr = w[25:21];
            2'd1:    bus.addr = w[20:16];
            default: bus.addr = r[8:4];
        endcase
        bus.data = $random(seed);
    endtask

    task automatic drive_random_inputs();
        inst_t w;
        random_inst(w);
        inst      = w;
        reg1_data = $random(seed);
        reg2_data = $random(seed);
        random_fwd(w, ex_fwd);
        random_fwd(w, mem_fwd);
    endtask

    initial
    begin
        clk         = 1'b0;
        rst         = 1'b1;
        inst        = '0;
        reg1_data   = '0;
        reg2_data   = '0;
        ex_fwd      = '0;
        mem_fwd     = '0;
        cur_exp     = '0;
        prev_exp    = '0;
        cur_valid   = 1'b0;
        prev_valid  = 1'b0;
        num_checked = 0;
        repeat (RST_CYCLES)
        begin
            @(negedge clk);
            drive_random_inputs();  // junk, reset has to win
        end
        check_value("o_id_ex.ctrl", 32'(id_ex.ctrl), 32'h0);
        check_value("o_id_ex.reg1", id_ex.reg1, 32'h0);
        check_value("o_id_ex.reg2", id_ex.reg2, 32'h0);
        rst = 1'b0;
        for (int i = 0; i < NUM_INST; i++)
        begin
            @(negedge clk);
            drive_random_inputs();
            cur_exp   = reference_decode(inst, reg1_data, reg2_data, ex_fwd, mem_fwd);
            cur_valid = 1'b1;
        end
        @(negedge clk);
        cur_valid = 1'b0;           // last result still to be checked
        #(CLK_PERIOD / 2);
        if (num_checked == NUM_INST)
        begin
            $display("TEST OK");
            $finish;
        end
        else
        begin
            $display("only %0d of %0d results were checked", num_checked, NUM_INST);
            $display("TEST FAILED");
            $fatal(1, "result count wrong");
        end
    end

    //////////////////////////////
    // compare
    //////////////////////////////

    always @(negedge clk)
    begin
        #1;  // new inputs settled, register holds the last edge
        if (prev_valid)
        begin
            check_value("o_id_ex.alusel", 32'(id_ex.ctrl.alusel), 32'(prev_exp.id_ex.ctrl.alusel));
            check_value("o_id_ex.aluop", 32'(id_ex.ctrl.aluop), 32'(prev_exp.id_ex.ctrl.aluop));
            check_value("o_id_ex.wreg", 32'(id_ex.ctrl.wreg), 32'(prev_exp.id_ex.ctrl.wreg));
            check_value("o_id_ex.wreg_addr", 32'(id_ex.ctrl.wreg_addr),
                        32'(prev_exp.id_ex.ctrl.wreg_addr));
            check_value("o_id_ex.reg1", id_ex.reg1, prev_exp.id_ex.reg1);
            check_value("o_id_ex.reg2", id_ex.reg2, prev_exp.id_ex.reg2);
            num_checked++;
        end
        if (cur_valid)
        begin
            check_value("o_rd1", 32'(rd1), 32'(cur_exp.rd1));  // same cycle
            check_value("o_rd2", 32'(rd2), 32'(cur_exp.rd2));
        end
        prev_exp   = cur_exp;
        prev_valid = cur_valid;
    end

    // bound property checker
    always @(DUT.u_id_stage_asserts.num_fail)
    begin
        if (DUT.u_id_stage_asserts.num_fail != 0)
        begin
            $display("a bound assertion on the decode stage failed");
            $display("TEST FAILED");
            $fatal(1, "assertion failure");
        end
    end

    // watchdog
    initial
    begin
        #(TIMEOUT_NS);
        $display("run did not finish in time, the testbench stopped it");
        $display("TEST FAILED");
        $fatal(1, "timeout");
    end

endmodule

`default_nettype wire

// File: list.f
src/mips_isa_pkg.sv
src/id_pkg.sv
src/inst_decode.sv
src/operand_select.sv
src/id_ex_reg.sv
src/id_stage.sv
tb/id_stage_asserts.sv
tb/tb_id_stage.sv

// File: Bender.yml
package:
  name: id_stage

sources:
  - src/mips_isa_pkg.sv
  - src/id_pkg.sv
  - src/inst_decode.sv
  - src/operand_select.sv
  - src/id_ex_reg.sv
  - src/id_stage.sv
  - target: test
    files:
      - tb/id_stage_asserts.sv
      - tb/tb_id_stage.sv
